// File: project.f
+incdir+include
hw/capture_pkg.sv
hw/trig_ctrl_if.sv
hw/sample_buffer.sv
hw/trigger_unit.sv
hw/sample_capture.sv
hw/capture_top.sv
dv/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the capture testbench with verilator and run it
# the run counts as good only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module capture_tb -o capture_sim \
  && ./obj_dir/capture_sim | tee sim.log \
  || { echo "build or run error"; exit 1; }

grep -qx "Simulation passed" sim.log \
  && echo "capture run ok" \
  || { echo "capture run FAILED"; exit 1; }

// File: dv/capture_tb.sv
module capture_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import capture_pkg::*;

  typedef struct {
    int      cyc;  // clock cycle the sample sat on the bus
    sample_t val;
  } adc_rec_t;

  typedef enum int {ARM_O, CAPTURE_ACTIVE_O, CAPTURE_GO_O, CAPTURE_DONE_O} watch_t;

  logic        reset;
  logic        adc_clk;
  sample_t     adc_data = '0;
  logic        trigger;
  logic        trigger_level;
  logic        trigger_wait;
  logic        trigger_now;
  logic        arm;
  count_t      trigger_offset;
  buf_addr_t   num_samples;
  buf_addr_t   rd_addr;
  sample_t     rd_data;
  logic        arm_st;
  logic        capture_active;
  logic        capture_go;
  logic        capture_done;
  count_t      trigger_length;

  int          cyc = 0;              // posedge count
  logic [31:0] lcg_state = 32'h0843_97a5;
  adc_rec_t    adc_hist [$];         // every driven adc sample
  adc_rec_t    rec_tmp;
  count_t      len_model;            // expected trigger_length_o
  logic        arm_prev;

  capture_top capture_top_inst (
    .reset            (reset),
    .adc_clk          (adc_clk),
    .adc_data_i       (adc_data),
    .trigger_i        (trigger),
    .trigger_level_i  (trigger_level),
    .trigger_wait_i   (trigger_wait),
    .trigger_now_i    (trigger_now),
    .arm_i            (arm),
    .trigger_offset_i (trigger_offset),
    .num_samples_i    (num_samples),
    .rd_addr_i        (rd_addr),
    .rd_data_o        (rd_data),
    .arm_o            (arm_st),
    .capture_active_o (capture_active),
    .capture_go_o     (capture_go),
    .capture_done_o   (capture_done),
    .trigger_length_o (trigger_length)
  );

  initial adc_clk = 1'b0;
  always #2 adc_clk = ~adc_clk; // 4 ns period

  always @(posedge adc_clk) cyc <= cyc + 1;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // new adc word every cycle logged with its cycle number
  always @(negedge adc_clk) begin
    lcg_state   = lcg_next(lcg_state);
    adc_data    = lcg_state[25:16]; // upper bits spread better
    rec_tmp.cyc = cyc;
    rec_tmp.val = adc_data;
    adc_hist.push_back(rec_tmp);
  end

  // go lands offset+2 cycles after the cycle the qualified trigger is presented
  function automatic int expected_go_cycle(int event_cyc, count_t offset);
    return event_cyc + int'(offset) + 2;
  endfunction

  // buffer word addr holds the sample seen addr cycles after go
  function automatic sample_t expected_word(int go_cyc, buf_addr_t addr);
    int want;
    want = go_cyc + int'(addr);
    foreach (adc_hist[i]) begin
      if (adc_hist[i].cyc == want) begin
        return adc_hist[i].val;
      end
    end
    return 'x;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_sample(string name, sample_t exp, sample_t act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(string name, count_t exp, count_t act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      stop_run();
    end
  endtask

  // length reference cleared by an arm edge and counting active pin cycles
  always @(posedge adc_clk) begin
    if (reset) begin
      len_model <= '0;
      arm_prev  <= 1'b0;
    end else begin
      arm_prev <= arm;
      if (arm && !arm_prev) begin
        len_model <= '0;
      end else if (trigger == trigger_level) begin
        len_model <= len_model + count_t'(1);
      end
    end
  end

  always @(negedge adc_clk) begin
    if (cyc > 16) begin // out of reset
      check_count("trigger_length_o", len_model, trigger_length);
    end
  end

  function automatic logic watched_bit(watch_t sel);
    case (sel)
      ARM_O:            return arm_st;
      CAPTURE_ACTIVE_O: return capture_active;
      CAPTURE_GO_O:     return capture_go;
      default:          return capture_done;
    endcase
  endfunction

  function automatic string watched_name(watch_t sel);
    case (sel)
      ARM_O:            return "arm_o";
      CAPTURE_ACTIVE_O: return "capture_active_o";
      CAPTURE_GO_O:     return "capture_go_o";
      default:          return "capture_done_o";
    endcase
  endfunction

  // returns at the first falling edge where sel is high
  task automatic await_high(watch_t sel, int limit, output int seen_cyc);
    int n;
    n = 0;
    do begin
      @(negedge adc_clk);
      n++;
      if (n > limit) begin
        $display("%s never went high within %0d cycles", watched_name(sel), limit);
        stop_run();
      end
    end while (watched_bit(sel) !== 1'b1);
    seen_cyc = cyc;
  endtask

  task automatic check_quiet(int n, logic arm_exp);
    repeat (n) begin
      @(negedge adc_clk);
      check_bit("arm_o", arm_exp, arm_st);
      check_bit("capture_active_o", 1'b0, capture_active);
      check_bit("capture_go_o", 1'b0, capture_go);
      check_bit("capture_done_o", 1'b0, capture_done);
    end
  endtask

  task automatic read_back(int go_cyc, buf_addr_t nsamp);
    for (int i = 0; i <= int'(nsamp); i++) begin
      rd_addr = buf_addr_t'(i);
      @(negedge adc_clk); // registered read port
      check_sample("rd_data_o", expected_word(go_cyc, buf_addr_t'(i)), rd_data);
    end
  endtask

  task automatic finish_capture(int go_cyc, buf_addr_t nsamp, logic level, logic keep_arm);
    int done_cyc;
    await_high(CAPTURE_DONE_O, int'(nsamp) + 16, done_cyc);
    check_bit("capture_done_o after last sample", 1'b1, done_cyc > go_cyc + int'(nsamp));
    check_count("trigger_length_o", len_model, trigger_length);
    trigger = ~level; // pin released
    if (!keep_arm) begin
      arm = 1'b0;
    end
    read_back(go_cyc, nsamp);
  endtask

  // arm with pin inactive and then drive it active
  task automatic run_capture(logic level, count_t offset, buf_addr_t nsamp, logic keep_arm);
    int seen;
    int ev_cyc;
    int go_cyc;
    trigger_level  = level;
    trigger        = ~level;
    trigger_wait   = 1'b0;
    trigger_offset = offset;
    num_samples    = nsamp;
    arm            = 1'b1;
    await_high(ARM_O, 8, seen);
    trigger = level;
    ev_cyc  = cyc;
    await_high(CAPTURE_GO_O, int'(offset) + 16, go_cyc);
    check_count("capture_go_o cycle", count_t'(expected_go_cycle(ev_cyc, offset)),
                count_t'(go_cyc));
    finish_capture(go_cyc, nsamp, level, keep_arm);
  endtask

  // pin already active when armed
  task automatic active_pin_capture(logic wait_first, count_t offset, buf_addr_t nsamp);
    int seen;
    int ev_cyc;
    int go_cyc;
    trigger_level  = 1'b1;
    trigger        = 1'b1;
    trigger_wait   = wait_first;
    trigger_offset = offset;
    num_samples    = nsamp;
    arm            = 1'b1;
    ev_cyc         = cyc + 1; // armed one cycle after the arm request
    await_high(ARM_O, 8, seen);
    check_count("arm_o rise cycle", count_t'(ev_cyc), count_t'(seen));
    if (wait_first) begin
      check_quiet(24, 1'b1); // held off until pin goes inactive
      trigger = 1'b0;
      repeat (2) @(negedge adc_clk);
      trigger = 1'b1;
      ev_cyc  = cyc;
    end
    await_high(CAPTURE_GO_O, int'(offset) + 16, go_cyc);
    check_count("capture_go_o cycle", count_t'(expected_go_cycle(ev_cyc, offset)),
                count_t'(go_cyc));
    finish_capture(go_cyc, nsamp, 1'b1, 1'b0);
  endtask

  task automatic forced_capture(count_t offset, buf_addr_t nsamp);
    int seen;
    int go_cyc;
    trigger_level  = 1'b1;
    trigger        = 1'b0;
    trigger_wait   = 1'b0;
    trigger_offset = offset;
    num_samples    = nsamp;
    arm            = 1'b1;
    await_high(ARM_O, 8, seen);
    trigger_now = 1'b1;
    await_high(CAPTURE_ACTIVE_O, 12, seen); // sync plus edge detect
    check_bit("capture_go_o", 1'b0, capture_go); // go only after active
    trigger_now = 1'b0;
    await_high(CAPTURE_GO_O, int'(offset) + 16, go_cyc);
    check_bit("capture_active_o", 1'b1, capture_active);
    finish_capture(go_cyc, nsamp, 1'b1, 1'b0);
  endtask

  initial begin
    reset          = 1'b1;
    arm            = 1'b0;
    trigger        = 1'b0;
    trigger_level  = 1'b1;
    trigger_wait   = 1'b0;
    trigger_now    = 1'b0;
    trigger_offset = '0;
    num_samples    = '0;
    rd_addr        = '0;
    repeat (16) @(negedge adc_clk);
    reset = 1'b0;

    check_quiet(20, 1'b0); // nothing before arm
    trigger = 1'b1;
    check_quiet(20, 1'b0); // pin alone does not capture
    trigger = 1'b0;

    run_capture(1'b1, count_t'(0), buf_addr_t'(15), 1'b0);
    run_capture(1'b1, count_t'(5), buf_addr_t'(31), 1'b0);
    run_capture(1'b1, count_t'(37), buf_addr_t'(63), 1'b0);

    active_pin_capture(1'b1, count_t'(4), buf_addr_t'(15));
    active_pin_capture(1'b0, count_t'(2), buf_addr_t'(15));

    forced_capture(count_t'(3), buf_addr_t'(31));

    // falling polarity with arm kept high after the first capture
    run_capture(1'b0, count_t'(9), buf_addr_t'(20), 1'b1);
    trigger = 1'b0;
    check_quiet(20, 1'b0); // no re-arm without arm edge
    trigger = 1'b1;
    arm     = 1'b0;
    repeat (4) @(negedge adc_clk);
    run_capture(1'b0, count_t'(12), buf_addr_t'(20), 1'b0);

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: hw/capture_top.sv
module capture_top (
  input  logic                   reset,
  input  logic                   adc_clk,
  input  capture_pkg::sample_t   adc_data_i,
  input  logic                   trigger_i,
  input  logic                   trigger_level_i,
  input  logic                   trigger_wait_i,
  input  logic                   trigger_now_i,
  input  logic                   arm_i,
  input  capture_pkg::count_t    trigger_offset_i,
  input  capture_pkg::buf_addr_t num_samples_i,
  input  capture_pkg::buf_addr_t rd_addr_i,        // host readback
  output capture_pkg::sample_t   rd_data_o,
  output logic                   arm_o,
  output logic                   capture_active_o,
  output logic                   capture_go_o,
  output logic                   capture_done_o,
  output capture_pkg::count_t    trigger_length_o
);
  import capture_pkg::*;

  trig_ctrl_if ctrl_if ();

  logic      wr_en;   // engine to memory
  buf_addr_t wr_addr;
  sample_t   wr_data;

  trigger_unit trigger_unit_inst (
    .reset            (reset),
    .adc_clk          (adc_clk),
    .trigger_i        (trigger_i),
    .trigger_level_i  (trigger_level_i),
    .trigger_wait_i   (trigger_wait_i),
    .trigger_now_i    (trigger_now_i),
    .arm_i            (arm_i),
    .trigger_offset_i (trigger_offset_i),
    .arm_o            (arm_o),
    .trigger_length_o (trigger_length_o),
    .ctrl             (ctrl_if.trig)
  );

  sample_capture sample_capture_inst (
    .reset         (reset),
    .adc_clk       (adc_clk),
    .adc_data_i    (adc_data_i),
    .num_samples_i (num_samples_i),
    .ctrl          (ctrl_if.cap),
    .wr_en_o       (wr_en),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data)
  );

  sample_buffer sample_buffer_inst (
    .adc_clk   (adc_clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .rd_addr_i (rd_addr_i),
    .wr_data_i (wr_data),
    .rd_data_o (rd_data_o)
  );

  // control status straight out for the host
  assign capture_active_o = ctrl_if.capture_active;
  assign capture_go_o     = ctrl_if.capture_go;
  assign capture_done_o   = ctrl_if.capture_done;

endmodule

// File: hw/sample_capture.sv
module sample_capture (
  input  logic                   reset,
  input  logic                   adc_clk,
  input  capture_pkg::sample_t   adc_data_i,
  input  capture_pkg::buf_addr_t num_samples_i, // samples minus one
  trig_ctrl_if.cap               ctrl,
  output logic                   wr_en_o,
  output capture_pkg::buf_addr_t wr_addr_o,
  output capture_pkg::sample_t   wr_data_o
);
  import capture_pkg::*;

  cap_state_t state_q;
  buf_addr_t  last_addr_q; // final address, frozen at start
  logic       last_wr;     // final write this cycle

  assign last_wr = wr_en_o && (wr_addr_o == last_addr_q);

  // ready for a new trigger whenever idle
  assign ctrl.armed_and_ready = (state_q == CAP_IDLE);

  // control path
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state_q           <= CAP_IDLE;
      wr_en_o           <= 1'b0;
      ctrl.capture_done <= 1'b0;
    end else begin
      ctrl.capture_done <= 1'b0; // pulse default
      case (state_q)
        CAP_IDLE: begin
          wr_en_o <= 1'b0;
          if (ctrl.capture_go) begin
            state_q <= CAP_RUN;
            wr_en_o <= 1'b1;     // sample 0 written next cycle
          end
        end
        CAP_RUN: begin
          if (!ctrl.capture_active) begin
            state_q <= CAP_IDLE; // host disarmed, abort quietly
            wr_en_o <= 1'b0;
          end else if (last_wr) begin
            state_q           <= CAP_IDLE;
            wr_en_o           <= 1'b0;
            ctrl.capture_done <= 1'b1;
          end
        end
        default: begin
          state_q <= CAP_IDLE;
          wr_en_o <= 1'b0;
        end
      endcase
    end
  end

  // write datapath, one register stage behind the adc bus
  always_ff @(posedge adc_clk) begin
    wr_data_o <= adc_data_i;
    if (state_q == CAP_IDLE) begin
      wr_addr_o   <= '0;
      last_addr_q <= num_samples_i; // latched on the go edge
    end else begin
      wr_addr_o <= wr_addr_o + 1'b1;
    end
  end

  // buffer writes only while capturing
  a_no_idle_write: assert property (
    @(posedge adc_clk) disable iff (reset)
    wr_en_o |-> (state_q != CAP_IDLE)
  );

endmodule

// File: hw/trigger_unit.sv
module trigger_unit (
  input  logic                reset,
  input  logic                adc_clk,
  input  logic                trigger_i,        // async trigger pin
  input  logic                trigger_level_i,  // 1 high or rising, 0 low or falling
  input  logic                trigger_wait_i,   // 1 needs inactive level before arming
  input  logic                trigger_now_i,    // async force trigger
  input  logic                arm_i,            // edge sensitive arm request
  input  capture_pkg::count_t trigger_offset_i, // go delay in adc cycles
  output logic                arm_o,            // internal arm status
  output capture_pkg::count_t trigger_length_o, // active trigger cycles since arm
  trig_ctrl_if.trig           ctrl
);
  import capture_pkg::*;

  logic [1:0] now_sync_q;        // trigger_now synchroniser
  logic       now_r_q;
  logic       now_r2_q;
  logic       trigger_now;       // single-cycle sync'd force
  logic       trig_hit;          // pin at active level
  logic       trig_event;        // qualified trigger this cycle
  logic       armed_q;
  logic       reset_arm_q;       // trigger taken, block re-arm
  logic       resetarm;
  logic       int_reset_capture;
  logic       go_start_q;        // offset delay running
  logic       triggered_q;       // one start per active period
  count_t     delay_cnt_q;
  logic       arm_dly_q;

  // trigger pin used raw so the event adds no sync latency
  assign trig_hit   = (trigger_i == trigger_level_i);
  assign trig_event = (trig_hit & armed_q) | trigger_now;

  // two flops for metastability then edge detect, 3 cycles to event
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      now_sync_q <= 2'b00;
      now_r_q    <= 1'b0;
      now_r2_q   <= 1'b0;
    end else begin
      {now_r2_q, now_r_q, now_sync_q} <= {now_r_q, now_sync_q, trigger_now_i};
    end
  end

  assign trigger_now = now_r_q & ~now_r2_q; // rising edge only

  // held after a trigger until host drops arm and capture has ended
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      reset_arm_q <= 1'b0;
    end else if (trig_event) begin
      reset_arm_q <= 1'b1;
    end else if (!arm_i && !ctrl.capture_active) begin
      reset_arm_q <= 1'b0;
    end
  end

  assign resetarm = reset | reset_arm_q;

  // armed once engine idle and wait condition met
  always_ff @(posedge adc_clk) begin
    if (resetarm) begin
      armed_q <= 1'b0;
    end else if (arm_i && ctrl.armed_and_ready && (!trig_hit || !trigger_wait_i)) begin
      armed_q <= 1'b1; // wait mode needs inactive level here
    end
  end

  // arm status follows request only
  always_ff @(posedge adc_clk) begin
    if (resetarm) begin
      arm_o <= 1'b0;
    end else if (arm_i) begin
      arm_o <= 1'b1;
    end
  end

  // done, disarm or reset end the capture
  assign int_reset_capture = reset | ctrl.capture_done | ~arm_i;

  always_ff @(posedge adc_clk) begin
    if (int_reset_capture) begin
      ctrl.capture_active <= 1'b0;
      go_start_q          <= 1'b0;
      triggered_q         <= 1'b0;
    end else begin
      if (trig_event) begin
        ctrl.capture_active <= 1'b1;
      end
      if (trig_event && !triggered_q) begin
        go_start_q <= 1'b1;       // start offset delay
      end else if (ctrl.capture_go) begin
        go_start_q <= 1'b0;       // delay finished
      end
      if (go_start_q) begin
        triggered_q <= 1'b1;
      end else if (!trig_hit) begin
        triggered_q <= 1'b0;      // pin released, next start allowed
      end
    end
  end

  // offset delay, go lands offset+1 edges after event edge
  always_ff @(posedge adc_clk) begin
    if (int_reset_capture || ctrl.capture_go) begin
      ctrl.capture_go <= 1'b0;    // one-cycle pulse
      delay_cnt_q     <= '0;
    end else if (go_start_q) begin
      if (delay_cnt_q == trigger_offset_i) begin
        ctrl.capture_go <= 1'b1;
      end else begin
        delay_cnt_q <= delay_cnt_q + 1'b1;
      end
    end
  end

  // trigger length, cleared by arm edge then counts active cycles
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      arm_dly_q        <= 1'b0;
      trigger_length_o <= '0;
    end else begin
      arm_dly_q <= arm_i;
      if (arm_i && !arm_dly_q) begin
        trigger_length_o <= '0;   // new arm
      end else if (trig_hit) begin
        trigger_length_o <= trigger_length_o + 1'b1;
      end
    end
  end

  // go is a single-cycle strobe per capture
  a_go_single: assert property (
    @(posedge adc_clk) disable iff (reset)
    ctrl.capture_go |=> !ctrl.capture_go
  );

  // engine only starts inside an active capture window
  a_go_active: assert property (
    @(posedge adc_clk) disable iff (reset)
    ctrl.capture_go |-> ctrl.capture_active
  );

endmodule

// File: hw/sample_buffer.sv
`include "capture_params.svh"

module sample_buffer (
  input  logic                   adc_clk,
  input  logic                   wr_en_i,
  input  capture_pkg::buf_addr_t wr_addr_i,
  input  capture_pkg::buf_addr_t rd_addr_i,
  input  capture_pkg::sample_t   wr_data_i,
  output capture_pkg::sample_t   rd_data_o
);
  import capture_pkg::*;

  localparam int unsigned DEPTH = `BUF_DEPTH;

  sample_t mem_q [DEPTH]; // plain array, maps to block ram

  // write port
  always_ff @(posedge adc_clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, data one cycle after address
  always_ff @(posedge adc_clk) begin
    rd_data_o <= mem_q[rd_addr_i];
  end

endmodule

// File: hw/trig_ctrl_if.sv
interface trig_ctrl_if;

  logic capture_go;      // one-cycle start, sample 0 on adc bus now
  logic capture_active;  // trigger seen, held until after done
  logic capture_done;    // one-cycle pulse after last write
  logic armed_and_ready; // capture engine idle

  // trigger side
  modport trig (
    output capture_go,
    output capture_active,
    input  capture_done,
    input  armed_and_ready
  );

  // capture engine side
  modport cap (
    input  capture_go,
    input  capture_active,
    output capture_done,
    output armed_and_ready
  );

endinterface

// File: hw/capture_pkg.sv
`include "capture_params.svh"

package capture_pkg;

  // one raw adc sample
  typedef logic [`ADC_WIDTH-1:0] sample_t;

  // buffer address, also used as sample count minus one
  typedef logic [`BUF_AW-1:0] buf_addr_t;

  // offset delay and trigger length count
  typedef logic [`CNT_WIDTH-1:0] count_t;

  // capture engine states
  typedef enum logic {
    CAP_IDLE, // waiting for capture_go
    CAP_RUN   // writing samples
  } cap_state_t;

endpackage

// File: include/capture_params.svh
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// adc sample word
`define ADC_WIDTH 10

// sample memory size, depth must equal 2**BUF_AW
`define BUF_DEPTH 256
`define BUF_AW 8

// offset delay and trigger length counters
`define CNT_WIDTH 32

`endif
